/* rtl/snake_text_pkg.sv */
`default_nettype none

package snake_text_pkg;

  typedef logic [7:0] char_t;                       // one screen cell code

  localparam char_t char_space     = 8'h20;
  localparam char_t numeric_offset = 8'h30;         // 0..9 -> '0'..'9'
  localparam char_t alpha_offset   = 8'h37;         // 10..15 -> 'A'..'F'

  localparam int banner_len = 14;

  // start banner, drawn left to right with a gap between letters
  localparam char_t banner_text [banner_len] = '{
    "E", "N", "T", "E", "R",
    " ",
    "t", "o",
    " ",
    "s", "t", "a", "r", "t"
  };

  localparam int score_row    = 2;
  localparam int score_hi_col = 3;                  // high nibble sits left
  localparam int score_lo_col = 4;

  localparam int banner_row  = 25;
  localparam int banner_col0 = 25;
  localparam int banner_step = 4;                   // columns per banner char

  typedef enum logic [2:0] {
    idle         = 3'd0,
    score_lo     = 3'd1,
    score_hi     = 3'd2,
    banner_write = 3'd3,
    banner_clear = 3'd4
  } text_state_e;

endpackage

`default_nettype wire

/* rtl/char_bus_pkg.sv */
`default_nettype none

package char_bus_pkg;

  localparam int col_bits = 7;                      // 128 columns per row slot
  localparam int row_bits = 6;

  typedef logic [row_bits+col_bits-1:0] addr_t;

  localparam int num_rows = 60;
  localparam int num_cols = 80;                     // visible part of a row

  // row in the upper bits, column in the lower col_bits
  function automatic addr_t cell_addr(input int row, input int col);
    return addr_t'((row << col_bits) | col);
  endfunction

endpackage

`default_nettype wire

/* rtl/char_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface char_bus_if;

  char_bus_pkg::addr_t   address;
  logic                  write;
  snake_text_pkg::char_t writedata;
  logic                  waitrequest;               // high stalls the write

  modport handler (
    output address,
    output write,
    output writedata,
    input  waitrequest
  );

  modport buffer (
    input  address,
    input  write,
    input  writedata,
    output waitrequest
  );

endinterface

`default_nettype wire

/* rtl/game_status_sync.sv */
`timescale 1ns/100ps
`default_nettype none

module game_status_sync #(
  parameter int score_bits = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  status_req,
  output logic                  status_ack,
  input  logic [score_bits-1:0] score,
  input  logic                  waiting,
  input  logic                  handler_idle,
  output logic [score_bits-1:0] snap_score,
  output logic                  snap_waiting
);

  logic take;                                       // accept a new request

  // only take a word when the previous cycle is fully closed
  assign take = status_req && !status_ack && handler_idle;

  always_ff @(posedge clk) begin
    if (reset) begin
      status_ack <= 1'b0;
    end else if (take) begin
      status_ack <= 1'b1;
    end else if (status_ack && !status_req) begin
      status_ack <= 1'b0;                           // game released req
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      snap_score   <= '0;
      snap_waiting <= 1'b1;                         // start screen after reset
    end else if (take) begin
      snap_score   <= score;
      snap_waiting <= waiting;
    end
  end

  // ack may only come up in answer to a pending request
  ack_needs_req_a : assert property (
    @(posedge clk) disable iff (reset)
    $rose(status_ack) |-> $past(status_req)
  );

endmodule

`default_nettype wire

/* rtl/text_handler.sv */
`timescale 1ns/100ps
`default_nettype none

module text_handler #(
  parameter int score_bits = 8
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [score_bits-1:0]       snap_score,
  input  logic                        snap_waiting,
  output logic                        handler_idle,
  output snake_text_pkg::text_state_e text_state,
  char_bus_if.handler                 bus
);

  snake_text_pkg::text_state_e state;
  logic [score_bits-1:0]       drawn_score;          // what is on screen now
  logic                        drawn_waiting;
  logic [3:0]                  banner_idx;
  logic                        accepted;
  logic                        banner_last;
  int                          banner_col;

  function automatic snake_text_pkg::char_t hex_char(input logic [3:0] nib);
    snake_text_pkg::char_t base;
    base = (nib >= 4'd10) ? snake_text_pkg::alpha_offset : snake_text_pkg::numeric_offset;
    return snake_text_pkg::char_t'(nib) + base;
  endfunction

  assign accepted    = bus.write && !bus.waitrequest;
  assign banner_last = (banner_idx == 4'(snake_text_pkg::banner_len - 1));
  assign banner_col  = snake_text_pkg::banner_col0 + snake_text_pkg::banner_step * banner_idx;

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= snake_text_pkg::banner_write;  // draw start screen
      drawn_score   <= '0;
      drawn_waiting <= 1'b1;
      banner_idx    <= '0;
    end else begin
      case (state)
        snake_text_pkg::idle: begin
          if (snap_score != drawn_score) begin       // score wins over flag
            state       <= snake_text_pkg::score_lo;
            drawn_score <= snap_score;
          end else if (snap_waiting != drawn_waiting) begin
            state         <= snap_waiting ? snake_text_pkg::banner_write
                                          : snake_text_pkg::banner_clear;
            drawn_waiting <= snap_waiting;
            banner_idx    <= '0;
          end
        end
        snake_text_pkg::score_lo: begin
          if (accepted) state <= snake_text_pkg::score_hi;
        end
        snake_text_pkg::score_hi: begin
          if (accepted) state <= snake_text_pkg::idle;
        end
        snake_text_pkg::banner_write,
        snake_text_pkg::banner_clear: begin
          if (accepted) begin
            banner_idx <= banner_idx + 4'd1;
            if (banner_last) state <= snake_text_pkg::idle;
          end
        end
        default: state <= snake_text_pkg::idle;
      endcase
    end
  end

  always_comb begin
    bus.write     = (state != snake_text_pkg::idle);
    bus.writedata = snake_text_pkg::char_space;
    bus.address   = '0;
    case (state)
      snake_text_pkg::score_lo: begin
        bus.writedata = hex_char(drawn_score[3:0]);
        bus.address   = char_bus_pkg::cell_addr(snake_text_pkg::score_row,
                                                snake_text_pkg::score_lo_col);
      end
      snake_text_pkg::score_hi: begin
        bus.writedata = hex_char(drawn_score[score_bits-1:4]);
        bus.address   = char_bus_pkg::cell_addr(snake_text_pkg::score_row,
                                                snake_text_pkg::score_hi_col);
      end
      snake_text_pkg::banner_write: begin
        bus.writedata = snake_text_pkg::banner_text[banner_idx];
        bus.address   = char_bus_pkg::cell_addr(snake_text_pkg::banner_row, banner_col);
      end
      snake_text_pkg::banner_clear: begin
        bus.address   = char_bus_pkg::cell_addr(snake_text_pkg::banner_row, banner_col);
      end
      default: ;
    endcase
  end

  assign handler_idle = (state == snake_text_pkg::idle);
  assign text_state   = state;

  // a stalled write keeps its cell and code until the buffer takes it
  write_held_a : assert property (
    @(posedge clk) disable iff (reset)
    (bus.write && bus.waitrequest) |=>
      bus.write && $stable(bus.address) && $stable(bus.writedata)
  );

endmodule

`default_nettype wire

/* rtl/char_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module char_buffer #(
  parameter int wait_cycles = 2
) (
  input  logic                  clk,
  input  logic                  reset,
  char_bus_if.buffer            bus,
  input  char_bus_pkg::addr_t   rd_addr,
  output snake_text_pkg::char_t rd_data
);

  localparam int cnt_bits = (wait_cycles > 0) ? $clog2(wait_cycles + 1) : 1;
  localparam int depth    = char_bus_pkg::num_rows << char_bus_pkg::col_bits;

  logic [cnt_bits-1:0]   wait_cnt;                  // stall cycles seen so far
  logic                  accept;
  snake_text_pkg::char_t mem [depth];

  // stall until the counter has run its course for this write
  assign bus.waitrequest = (wait_cnt < cnt_bits'(wait_cycles));
  assign accept          = bus.write && !bus.waitrequest;

  always_ff @(posedge clk) begin
    if (reset) begin
      wait_cnt <= '0;
    end else if (accept) begin
      wait_cnt <= '0;                               // next write stalls again
    end else if (bus.write) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // blank screen from power-up
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = snake_text_pkg::char_space;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mem[bus.address] <= bus.writedata;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];                        // one cycle read for renderer
  end

  // handler must stay inside the visible part of each row
  col_in_range_a : assert property (
    @(posedge clk) disable iff (reset)
    accept |-> (bus.address[char_bus_pkg::col_bits-1:0] < char_bus_pkg::num_cols)
  );

endmodule

`default_nettype wire

/* rtl/snake_text_top.sv */
`timescale 1ns/100ps
`default_nettype none

module snake_text_top #(
  parameter int wait_cycles = 2,
  parameter int score_bits  = 8
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        status_req,
  output logic                        status_ack,
  input  logic [score_bits-1:0]       score,
  input  logic                        waiting,
  input  char_bus_pkg::addr_t         rd_addr,
  output snake_text_pkg::char_t       rd_data,
  output snake_text_pkg::text_state_e text_state
);

  logic [score_bits-1:0] snap_score;
  logic                  snap_waiting;
  logic                  handler_idle;              // gates new requests

  char_bus_if bus_i ();

  game_status_sync #(.score_bits(score_bits)) sync_i (
    .clk          (clk),
    .reset        (reset),
    .status_req   (status_req),
    .status_ack   (status_ack),
    .score        (score),
    .waiting      (waiting),
    .handler_idle (handler_idle),
    .snap_score   (snap_score),
    .snap_waiting (snap_waiting)
  );

  text_handler #(.score_bits(score_bits)) handler_i (
    .clk          (clk),
    .reset        (reset),
    .snap_score   (snap_score),
    .snap_waiting (snap_waiting),
    .handler_idle (handler_idle),
    .text_state   (text_state),
    .bus          (bus_i.handler)
  );

  char_buffer #(.wait_cycles(wait_cycles)) buffer_i (
    .clk     (clk),
    .reset   (reset),
    .bus     (bus_i.buffer),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

/* dv/snake_text_checks.sv */
`timescale 1ns/100ps
`default_nettype none

module snake_text_checks (
  input logic                        clk,
  input logic                        reset,
  input logic                        status_req,
  input logic                        status_ack,
  input snake_text_pkg::text_state_e text_state
);

  int unsigned fail_count = 0;                      // failed assertions so far

  // start screen is being drawn as soon as reset lets go
  out_of_reset_c : assert property (
    @(posedge clk) $fell(reset) |-> (text_state == snake_text_pkg::banner_write) && !status_ack
  ) else begin
    $error("handler did not start drawing the banner after reset");
    fail_count++;
  end

  ack_rise_c : assert property (
    @(posedge clk) disable iff (reset)
    $rose(status_ack) |-> $past(status_req)
  ) else begin
    $error("status_ack rose while status_req was low");
    fail_count++;
  end

  ack_fall_c : assert property (
    @(posedge clk) disable iff (reset)
    $fell(status_ack) |-> !$past(status_req)
  ) else begin
    $error("status_ack fell while status_req was still high");
    fail_count++;
  end

  // busy handler holds off a new word
  req_held_c : assert property (
    @(posedge clk) disable iff (reset)
    (status_req && !status_ack && text_state != snake_text_pkg::idle) |=> !status_ack
  ) else begin
    $error("status_ack given while the handler was busy");
    fail_count++;
  end

  req_taken_c : assert property (
    @(posedge clk) disable iff (reset)
    (status_req && !status_ack && text_state == snake_text_pkg::idle) |=> status_ack
  ) else begin
    $error("pending request not acknowledged once handler was idle");
    fail_count++;
  end

endmodule

`default_nettype wire

/* dv/snake_text_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module snake_text_tb;

  localparam int wait_cycles = 2;
  localparam int score_bits  = 8;
  localparam int clk_period  = 20;
  localparam int max_updates = 40;                  // generous upper bound on jobs
  localparam int watchdog_ns = 2 * max_updates * snake_text_pkg::banner_len
                               * (wait_cycles + 1) * clk_period;

  logic                        clk;
  logic                        reset;
  logic                        status_req;
  logic                        status_ack;
  logic [score_bits-1:0]       score;
  logic                        waiting;
  char_bus_pkg::addr_t         rd_addr;
  snake_text_pkg::char_t       rd_data;
  snake_text_pkg::text_state_e text_state;
  integer                      seed;
  logic [score_bits-1:0]       cur;
  string                       banner_str = "ENTER to start";
  string                       hex_digits = "0123456789ABCDEF";

  snake_text_top #(.wait_cycles(wait_cycles), .score_bits(score_bits)) dut_i (
    .clk        (clk),
    .reset      (reset),
    .status_req (status_req),
    .status_ack (status_ack),
    .score      (score),
    .waiting    (waiting),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .text_state (text_state)
  );

  bind snake_text_top snake_text_checks checks_i (
    .clk        (clk),
    .reset      (reset),
    .status_req (status_req),
    .status_ack (status_ack),
    .text_state (text_state)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    stop_on_error($sformatf("simulation timed out after %0d ns", watchdog_ns));
  end

  initial begin
    wait (dut_i.checks_i.fail_count != 0);
    stop_on_error("an assertion in the bound checker failed");
  end

  // one full four-phase cycle with the game side
  task automatic send_status(input logic [score_bits-1:0] s, input logic w);
    @(posedge clk);
    score      <= s;
    waiting    <= w;
    status_req <= 1'b1;
    do @(negedge clk); while (!status_ack);
    @(posedge clk);
    status_req <= 1'b0;
    do @(negedge clk); while (status_ack);
  endtask

  // idle for two samples means no queued job is left
  task automatic wait_idle();
    int idle_run;
    idle_run = 0;
    while (idle_run < 2) begin
      @(negedge clk);
      if (text_state == snake_text_pkg::idle) begin
        idle_run++;
      end else begin
        idle_run = 0;
      end
    end
  endtask

  task automatic check_cell(input int row, input int col, input snake_text_pkg::char_t exp);
    snake_text_pkg::char_t got;
    @(posedge clk);
    rd_addr <= char_bus_pkg::addr_t'((row << char_bus_pkg::col_bits) | col);
    @(posedge clk);
    @(negedge clk);
    got = rd_data;                                  // one cycle read latency
    assert (got === exp)
      else stop_on_error($sformatf("Error at %0t: rd_data at row %0d col %0d is %h, expected %h",
                                   $time, row, col, got, exp));
  endtask

  task automatic check_banner(input logic shown);
    for (int i = 0; i < snake_text_pkg::banner_len; i++) begin
      check_cell(snake_text_pkg::banner_row,
                 snake_text_pkg::banner_col0 + snake_text_pkg::banner_step * i,
                 shown ? banner_str[i] : snake_text_pkg::char_space);
    end
  endtask

  task automatic check_score(input logic [score_bits-1:0] s);
    check_cell(snake_text_pkg::score_row, snake_text_pkg::score_lo_col, hex_digits[s[3:0]]);
    check_cell(snake_text_pkg::score_row, snake_text_pkg::score_hi_col, hex_digits[s[7:4]]);
  endtask

  function automatic logic [score_bits-1:0] fresh_score(input logic [score_bits-1:0] old);
    logic [score_bits-1:0] s;
    s = score_bits'($random(seed));
    if (s == old) begin
      s = ~old;                                     // force a real change
    end
    return s;
  endfunction

  initial begin
    seed       = 2342;
    reset      <= 1'b1;
    status_req <= 1'b0;
    score      <= '0;
    waiting    <= 1'b1;
    rd_addr    <= '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    wait_idle();
    check_banner(1'b1);
    cur = '0;
    repeat (4) begin
      cur = fresh_score(cur);
      send_status(cur, 1'b1);
      wait_idle();
      check_score(cur);
      check_banner(1'b1);
    end
    send_status(cur, 1'b0);
    wait_idle();
    check_banner(1'b0);
    check_score(cur);
    send_status(cur, 1'b1);
    wait_idle();
    check_banner(1'b1);
    // second word arrives while the score digits are still being written
    cur = fresh_score(cur);
    send_status(cur, 1'b1);
    send_status(cur, 1'b0);
    wait_idle();
    check_score(cur);
    check_banner(1'b0);
    cur = fresh_score(cur);
    send_status(cur, 1'b1);                         // score and flag together
    wait_idle();
    check_score(cur);
    check_banner(1'b1);
    send_status(cur, 1'b1);                         // unchanged word
    // a job would have started one cycle after the ack
    assert (text_state == snake_text_pkg::idle)
      else stop_on_error($sformatf("Error at %0t: text_state is %s, expected idle",
                                   $time, text_state.name()));
    wait_idle();
    check_score(cur);
    check_banner(1'b1);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
rtl/snake_text_pkg.sv
rtl/char_bus_pkg.sv
rtl/char_bus_if.sv
rtl/game_status_sync.sv
rtl/text_handler.sv
rtl/char_buffer.sv
rtl/snake_text_top.sv
dv/snake_text_checks.sv
dv/snake_text_tb.sv

/* Bender.yml */
package:
  name: snake_text

sources:
  - rtl/snake_text_pkg.sv
  - rtl/char_bus_pkg.sv
  - rtl/char_bus_if.sv
  - rtl/game_status_sync.sv
  - rtl/text_handler.sv
  - rtl/char_buffer.sv
  - rtl/snake_text_top.sv

  - target: test
    files:
      - dv/snake_text_checks.sv
      - dv/snake_text_tb.sv
